// File: logic/match_pkg.sv
// Pattern matcher shared definitions
`default_nettype none

package match_pkg;

    // Stream word and pattern width
    localparam int DATA_W = 8;

    // Host command word width
    localparam int CMD_W = 16;

    // Opcodes sit in the top two bits of every command word
    // Value 3 is not assigned and is reported as a bad command
    localparam logic [1:0] OP_NOP   = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_CTRL  = 2'd2;

    // Write view, loads one pattern bank
    typedef struct packed {
        logic [1:0]        opcode;
        logic              bank;
        logic [4:0]        rsvd;
        logic [DATA_W-1:0] value;
    } cmd_write_t;

    // Control view, swap and clear flags
    typedef struct packed {
        logic [1:0]  opcode;
        logic        swap;
        logic        clear;
        logic [11:0] rsvd;
    } cmd_ctrl_t;

    // Same 16 bits, decoded by opcode
    typedef union packed {
        cmd_write_t wr;
        cmd_ctrl_t  ctrl;
    } cmd_word_u;

endpackage

`default_nettype wire

// File: logic/cmd_decoder.sv
// Host command decoder
`default_nettype none

module cmd_decoder (
    input  wire                           clk,
    input  wire                           rst_n,
    input  logic                          cmd_valid,
    input  logic [match_pkg::CMD_W-1:0]   cmd,
    output logic                          wr_en,
    output logic                          wr_bank,
    output logic [match_pkg::DATA_W-1:0]  wr_value,
    output logic                          swap,
    output logic                          clear,
    output logic                          bad_cmd
);

    import match_pkg::*;

    cmd_word_u cw;
    logic      is_write;
    logic      is_ctrl;
    logic      is_bad;

    assign cw = cmd;

    // Opcode field is at the same place in both views
    always_comb begin
        is_write = 1'b0;
        is_ctrl  = 1'b0;
        is_bad   = 1'b0;
        if (cmd_valid) begin
            case (cw.wr.opcode)
                OP_NOP: begin
                    // Nothing to do
                end
                OP_WRITE: is_write = 1'b1;
                OP_CTRL:  is_ctrl  = 1'b1;
                default:  is_bad   = 1'b1;
            endcase
        end
    end

    // One-cycle pulses, high in the cycle after the command edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            swap    <= 1'b0;
            clear   <= 1'b0;
            bad_cmd <= 1'b0;
        end else begin
            wr_en   <= is_write;
            swap    <= is_ctrl && cw.ctrl.swap;
            clear   <= is_ctrl && cw.ctrl.clear;
            bad_cmd <= is_bad;
        end
    end

    // Write target and value, only meaningful while wr_en is high
    always_ff @(posedge clk) begin
        if (is_write) begin
            wr_bank  <= cw.wr.bank;
            wr_value <= cw.wr.value;
        end
    end

    // A single command word can never be both a write and illegal
    a_write_not_bad: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr_en && bad_cmd)
    ) else $error("wr_en and bad_cmd high together");

endmodule

`default_nettype wire

// File: logic/pattern_bank.sv
// Double-buffered pattern store
`default_nettype none

module pattern_bank (
    input  wire                           clk,
    input  wire                           rst_n,
    input  logic                          wr_en,
    input  logic                          wr_bank,
    input  logic [match_pkg::DATA_W-1:0]  wr_value,
    input  logic                          swap,
    output logic [match_pkg::DATA_W-1:0]  pattern0,
    output logic [match_pkg::DATA_W-1:0]  pattern1,
    output logic                          active_sel
);

    logic load0;
    logic load1;

    // Bank address picks which register takes the value
    assign load0 = wr_en && !wr_bank;
    assign load1 = wr_en && wr_bank;

    // Bank 0 pattern
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pattern0 <= '0;
        end else if (load0) begin
            pattern0 <= wr_value;
        end
    end

    // Bank 1 pattern
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pattern1 <= '0;
        end else if (load1) begin
            pattern1 <= wr_value;
        end
    end

    // Live bank flag, toggled by swap
    // A write in the same cycle still lands, whichever bank it targets
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_sel <= 1'b0;
        end else if (swap) begin
            active_sel <= ~active_sel;
        end
    end

endmodule

`default_nettype wire

// File: logic/stream_matcher.sv
// Pipelined stream word matcher
`default_nettype none

module stream_matcher (
    input  wire                           clk,
    input  wire                           rst_n,
    input  logic                          data_valid,
    input  logic [match_pkg::DATA_W-1:0]  data,
    input  logic [match_pkg::DATA_W-1:0]  pattern0,
    input  logic [match_pkg::DATA_W-1:0]  pattern1,
    input  logic                          active_sel,
    output logic                          match_valid,
    output logic                          match
);

    import match_pkg::*;

    // Stage 1, sampled inputs
    logic [DATA_W-1:0] data_s1;
    logic [DATA_W-1:0] pat0_s1;
    logic [DATA_W-1:0] pat1_s1;
    logic              sel_s1;
    logic              valid_s1;

    // Stage 2, chosen pattern
    logic [DATA_W-1:0] data_s2;
    logic [DATA_W-1:0] pat_s2;
    logic              valid_s2;

    // Stage 3, compare result
    logic              eq_s3;
    logic              valid_s3;

    // Valid bits follow data_valid through every stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end else begin
            valid_s1 <= data_valid;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
        end
    end

    // Word and pattern path
    always_ff @(posedge clk) begin
        data_s1 <= data;
        pat0_s1 <= pattern0;
        pat1_s1 <= pattern1;
        sel_s1  <= active_sel;
        data_s2 <= data_s1;
        pat_s2  <= sel_s1 ? pat1_s1 : pat0_s1;
        eq_s3   <= (data_s2 == pat_s2);
    end

    // Result register, match only counts on a valid slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_valid <= 1'b0;
            match       <= 1'b0;
        end else begin
            match_valid <= valid_s3;
            match       <= valid_s3 && eq_s3;
        end
    end

    // A hit must belong to a word taken four sampling edges before
    a_match_has_word: assert property (
        @(posedge clk) disable iff (!rst_n)
        match |-> match_valid && $past(data_valid, 4)
    ) else $error("match without a valid result slot");

endmodule

`default_nettype wire

// File: logic/match_tally.sv
// Word and match counters
`default_nettype none

module match_tally #(
    parameter int COUNT_W = 16
) (
    input  wire                clk,
    input  wire                rst_n,
    input  logic               match_valid,
    input  logic               match,
    input  logic               clear,
    output logic [COUNT_W-1:0] word_count,
    output logic [COUNT_W-1:0] match_count
);

    // Set once word_count rolls over, until the next clear
    logic wrapped;

    // Clear has priority over a result arriving in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_count  <= '0;
            match_count <= '0;
        end else if (clear) begin
            word_count  <= '0;
            match_count <= '0;
        end else if (match_valid) begin
            word_count <= word_count + 1'b1;
            if (match) begin
                match_count <= match_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrapped <= 1'b0;
        end else if (clear) begin
            wrapped <= 1'b0;
        end else if (match_valid && (&word_count)) begin
            wrapped <= 1'b1;
        end
    end

    // Hits are a subset of results until the word counter wraps
    a_hits_le_words: assert property (
        @(posedge clk) disable iff (!rst_n) !wrapped |-> match_count <= word_count
    ) else $error("match_count above word_count");

endmodule

`default_nettype wire

// File: logic/pattern_match_top.sv
// Stream pattern matcher top
`default_nettype none

module pattern_match_top #(
    parameter int COUNT_W = 16
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  logic                          cmd_valid,
    input  logic [match_pkg::CMD_W-1:0]   cmd,
    input  logic                          data_valid,
    input  logic [match_pkg::DATA_W-1:0]  data,
    output logic                          match_valid,
    output logic                          match,
    output logic [COUNT_W-1:0]            word_count,
    output logic [COUNT_W-1:0]            match_count,
    output logic                          bad_cmd,
    output logic                          active_sel
);

    import match_pkg::*;

    // Decoder outputs
    logic              wr_en;
    logic              wr_bank;
    logic [DATA_W-1:0] wr_value;
    logic              swap;
    logic              clear;

    // Stored patterns
    logic [DATA_W-1:0] pattern0;
    logic [DATA_W-1:0] pattern1;

    cmd_decoder i_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_value  (wr_value),
        .swap      (swap),
        .clear     (clear),
        .bad_cmd   (bad_cmd)
    );

    pattern_bank i_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .wr_value   (wr_value),
        .swap       (swap),
        .pattern0   (pattern0),
        .pattern1   (pattern1),
        .active_sel (active_sel)
    );

    stream_matcher i_matcher (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_valid  (data_valid),
        .data        (data),
        .pattern0    (pattern0),
        .pattern1    (pattern1),
        .active_sel  (active_sel),
        .match_valid (match_valid),
        .match       (match)
    );

    match_tally #(
        .COUNT_W (COUNT_W)
    ) i_tally (
        .clk         (clk),
        .rst_n       (rst_n),
        .match_valid (match_valid),
        .match       (match),
        .clear       (clear),
        .word_count  (word_count),
        .match_count (match_count)
    );

endmodule

`default_nettype wire

// File: tests/tb_pattern_match.sv
// Pattern matcher testbench
`default_nettype none

module tb_pattern_match;

    import match_pkg::*;

    localparam int COUNT_W = 16;
    localparam int RESULT_TIMEOUT = 20;

    logic               clk;
    logic               rst_n;
    logic               cmd_valid;
    logic [CMD_W-1:0]   cmd;
    logic               data_valid;
    logic [DATA_W-1:0]  data;
    logic               match_valid;
    logic               match;
    logic [COUNT_W-1:0] word_count;
    logic [COUNT_W-1:0] match_count;
    logic               bad_cmd;
    logic               active_sel;

    // Reference model state
    logic [DATA_W-1:0]  model_pat [2];
    logic               model_sel;
    int                 model_words;
    int                 model_hits;
    bit                 exp_match_q [$];
    int                 exp_edge_q [$];

    int                 cycle_cnt = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests_run = 0;
    logic [31:0]        rng = 32'd13713;

    pattern_match_top #(
        .COUNT_W (COUNT_W)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .data_valid  (data_valid),
        .data        (data),
        .match_valid (match_valid),
        .match       (match),
        .word_count  (word_count),
        .match_count (match_count),
        .bad_cmd     (bad_cmd),
        .active_sel  (active_sel)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Edge number, read only on falling edges
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Command words built from the documented field layout
    function automatic logic [CMD_W-1:0] write_cmd(input logic bank, input logic [7:0] value);
        return {2'd1, bank, 5'd0, value};
    endfunction

    function automatic logic [CMD_W-1:0] ctrl_cmd(input logic do_swap, input logic do_clear);
        return {2'd2, do_swap, do_clear, 12'd0};
    endfunction

    task automatic model_cmd(input logic [CMD_W-1:0] word);
        case (word[15:14])
            2'd1: model_pat[word[13]] = word[7:0];
            2'd2: begin
                if (word[13]) model_sel = ~model_sel;
                if (word[12]) begin
                    model_words = 0;
                    model_hits  = 0;
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_counts();
        int mask;
        mask = (1 << COUNT_W) - 1;
        check_eq("word_count", 32'(word_count), 32'(model_words & mask));
        check_eq("match_count", 32'(match_count), 32'(model_hits & mask));
    endtask

    // Command pulse, then three idle cycles before data may follow
    task automatic send_cmd(input logic [CMD_W-1:0] word);
        logic exp_bad;
        exp_bad = (word[15:14] == 2'd3);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = word;
        model_cmd(word);
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = '0;
        check_eq("bad_cmd", 32'(bad_cmd), 32'(exp_bad));
        @(negedge clk);
        check_eq("bad_cmd", 32'(bad_cmd), 32'd0);
        repeat (2) @(negedge clk);
        check_eq("active_sel", 32'(active_sel), 32'(model_sel));
        check_counts();
    endtask

    // Drives one word; a burst ends with drain_results
    task automatic send_word(input logic [DATA_W-1:0] word);
        bit hit;
        hit = (word == model_pat[model_sel]);
        @(negedge clk);
        data_valid = 1'b1;
        data       = word;
        exp_match_q.push_back(hit);
        exp_edge_q.push_back(cycle_cnt + 1);
        model_words++;
        if (hit) model_hits++;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        @(negedge clk);
        data_valid = 1'b0;
        data       = '0;
        while (exp_match_q.size() != 0 && waited < RESULT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_match_q.size() != 0) begin
            $display("Timeout at %0t: %0d results never arrived", $time, exp_match_q.size());
            errors++;
            exp_match_q.delete();
            exp_edge_q.delete();
        end
        // Counters follow the last result by one edge
        repeat (2) @(negedge clk);
        check_counts();
    endtask

    // Result monitor, compares each result with the queued expectation
    always @(negedge clk) begin
        if (rst_n && match_valid) begin
            if (exp_match_q.size() == 0) begin
                $display("Error at %0t: result arrived with no word in flight", $time);
                errors++;
            end else begin
                check_eq("match", 32'(match), 32'(exp_match_q.pop_front()));
                check_eq("match_valid latency", 32'(cycle_cnt - exp_edge_q.pop_front()), 32'd3);
            end
        end
    end

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("%s: done, %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset_state();
        int e;
        e = errors;
        check_eq("active_sel", 32'(active_sel), 32'd0);
        check_eq("match_valid", 32'(match_valid), 32'd0);
        check_eq("match", 32'(match), 32'd0);
        check_eq("bad_cmd", 32'(bad_cmd), 32'd0);
        check_counts();
        finish_test("reset_state", e);
    endtask

    task automatic test_bank_match();
        int e;
        e = errors;
        send_cmd(write_cmd(1'b0, 8'h5A));
        send_cmd(write_cmd(1'b1, 8'hC3));
        send_word(8'h5A);
        send_word(8'hC3);
        send_word(8'h11);
        drain_results();
        finish_test("bank_match", e);
    endtask

    task automatic test_swap();
        int e;
        e = errors;
        send_cmd(ctrl_cmd(1'b1, 1'b0));
        send_word(8'h5A);
        send_word(8'hC3);
        send_word(8'h11);
        drain_results();
        send_cmd(ctrl_cmd(1'b1, 1'b0));
        send_word(8'hC3);
        send_word(8'h5A);
        drain_results();
        finish_test("swap", e);
    endtask

    task automatic test_random_stream();
        int e;
        logic [DATA_W-1:0] word;
        e = errors;
        for (int i = 0; i < 40; i++) begin
            rng = xorshift(rng);
            // Bit 8 forces roughly half the words onto the live pattern
            word = rng[8] ? model_pat[model_sel] : rng[7:0];
            send_word(word);
        end
        drain_results();
        finish_test("random_stream", e);
    endtask

    task automatic test_clear_and_bad();
        int e;
        e = errors;
        send_cmd(ctrl_cmd(1'b0, 1'b1));
        send_word(8'h5A);
        send_word(8'h77);
        drain_results();
        send_cmd(ctrl_cmd(1'b1, 1'b1));
        // Opcode 3 with bits that would look like a write or a swap
        send_cmd(16'hE05A);
        send_word(8'h5A);
        send_word(8'hC3);
        send_word(8'h00);
        drain_results();
        finish_test("clear_and_bad", e);
    endtask

    initial begin
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        data_valid   = 1'b0;
        data         = '0;
        model_pat[0] = '0;
        model_pat[1] = '0;
        model_sel    = 1'b0;
        model_words  = 0;
        model_hits   = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_bank_match();
        test_swap();
        test_random_stream();
        test_clear_and_bad();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/match_pkg.sv
logic/cmd_decoder.sv
logic/pattern_bank.sv
logic/stream_matcher.sv
logic/match_tally.sv
logic/pattern_match_top.sv
tests/tb_pattern_match.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pattern matcher simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_pattern_match \
    -o sim_pattern_match

out=$(./obj_dir/sim_pattern_match)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
